//--- hdl/hdc_pkg.sv
/*
 * Shared sizes, types and the host register map of the HDC encoder.
 * Every RTL block takes these by a wildcard import in its header.
 */
`default_nettype none

package hdc_pkg;

  // --------------------------------------------------
  // Sizes
  // --------------------------------------------------
  localparam int unsigned HV_DIM     = 32;
  localparam int unsigned IM_DEPTH   = 16;
  localparam int unsigned IM_ADDR_W  = 4;
  localparam int unsigned COUNT_W    = 8;
  localparam int unsigned CSR_ADDR_W = 8;
  localparam int unsigned CSR_DATA_W = 32;

  typedef logic [HV_DIM-1:0]     hv_t;
  typedef logic [IM_ADDR_W-1:0]  im_addr_t;
  typedef logic [COUNT_W-1:0]    count_t;
  typedef logic [CSR_DATA_W-1:0] csr_data_t;
  typedef logic [CSR_ADDR_W-1:0] csr_addr_t;

  // --------------------------------------------------
  // Register map, word addresses
  // --------------------------------------------------
  localparam csr_addr_t REG_CTRL      = 8'h00;
  localparam csr_addr_t REG_NUM_ITEMS = 8'h01;
  localparam csr_addr_t REG_BASE_A    = 8'h02;
  localparam csr_addr_t REG_BASE_B    = 8'h03;
  localparam csr_addr_t REG_STATUS    = 8'h04;
  localparam csr_addr_t REG_RESULT    = 8'h05;

  // Item k lives at IM_WIN_BASE + k
  localparam csr_addr_t IM_WIN_BASE   = 8'h10;

  // Bit positions inside CTRL and STATUS
  localparam int unsigned CTRL_START_BIT  = 0;
  localparam int unsigned STATUS_BUSY_BIT = 0;
  localparam int unsigned STATUS_DONE_BIT = 1;

endpackage

`default_nettype wire

//--- hdl/hdc_csr.sv
/*
 * Host register block of the HDC encoder.
 * Single-cycle write and read strobes, read data one cycle later.
 * Holds the run settings, turns CTRL writes into a start strobe
 * and forwards item-memory window writes one cycle after the strobe.
 */
`default_nettype none

module hdc_csr import hdc_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_i,
  input  logic      csr_we_i,
  input  logic      csr_re_i,
  input  csr_addr_t csr_addr_i,
  input  csr_data_t csr_wdata_i,
  input  logic      busy_i,
  input  logic      done_i,
  input  hv_t       result_i,
  output csr_data_t csr_rdata_o,
  output logic      csr_rvalid_o,
  output logic      start_req_o,
  output count_t    num_items_o,
  output im_addr_t  base_a_o,
  output im_addr_t  base_b_o,
  output logic      im_wr_en_o,
  output im_addr_t  im_wr_addr_o,
  output hv_t       im_wr_data_o
);

  logic      win_hit;
  csr_data_t rdata_d;

  // Upper address bits select the 16-entry window
  assign win_hit = (csr_addr_i[CSR_ADDR_W-1:IM_ADDR_W] ==
                    IM_WIN_BASE[CSR_ADDR_W-1:IM_ADDR_W]);

  // --------------------------------------------------
  // Run settings
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      num_items_o <= '0;
      base_a_o    <= '0;
      base_b_o    <= '0;
    end else if (csr_we_i) begin
      case (csr_addr_i)
        REG_NUM_ITEMS: num_items_o <= csr_wdata_i[COUNT_W-1:0];
        REG_BASE_A:    base_a_o    <= csr_wdata_i[IM_ADDR_W-1:0];
        REG_BASE_B:    base_b_o    <= csr_wdata_i[IM_ADDR_W-1:0];
        default: ;
      endcase
    end
  end

  // One-cycle strobes
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      start_req_o  <= 1'b0;
      im_wr_en_o   <= 1'b0;
      csr_rvalid_o <= 1'b0;
    end else begin
      start_req_o  <= csr_we_i && (csr_addr_i == REG_CTRL) && csr_wdata_i[CTRL_START_BIT];
      im_wr_en_o   <= csr_we_i && win_hit;
      csr_rvalid_o <= csr_re_i;
    end
  end

  // --------------------------------------------------
  // Read mux, unmapped addresses give zero
  // --------------------------------------------------
  always_comb begin
    rdata_d = '0;
    case (csr_addr_i)
      REG_NUM_ITEMS: rdata_d = csr_data_t'(num_items_o);
      REG_BASE_A:    rdata_d = csr_data_t'(base_a_o);
      REG_BASE_B:    rdata_d = csr_data_t'(base_b_o);
      REG_STATUS: begin
        rdata_d[STATUS_BUSY_BIT] = busy_i;
        rdata_d[STATUS_DONE_BIT] = done_i;
      end
      REG_RESULT:    rdata_d = result_i;
      default: ;
    endcase
  end

  always_ff @(posedge clk_i) begin
    im_wr_addr_o <= csr_addr_i[IM_ADDR_W-1:0];
    im_wr_data_o <= csr_wdata_i;
    if (csr_re_i) begin
      csr_rdata_o <= rdata_d;
    end
  end

endmodule

`default_nettype wire

//--- hdl/im_fetcher.sv
/*
 * Item-memory address walker with a one-entry holding register.
 * Loads base and count on run_start, then requests one address at a
 * time while the holding register is empty. Used for port A and B.
 */
`default_nettype none

module im_fetcher import hdc_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     run_start_i,
  input  im_addr_t base_i,
  input  count_t   num_items_i,
  input  logic     gnt_i,
  input  logic     rvalid_i,
  input  hv_t      rdata_i,
  input  logic     pop_i,
  output logic     req_o,
  output im_addr_t addr_o,
  output hv_t      hv_o,
  output logic     full_o
);

  count_t left_q;
  logic   pending_q;

  // Held until granted, addr only moves on a grant
  assign req_o = !full_o && !pending_q && (left_q != '0);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      left_q    <= '0;
      addr_o    <= '0;
      pending_q <= 1'b0;
      full_o    <= 1'b0;
    end else begin
      if (run_start_i) begin
        left_q <= num_items_i;
        addr_o <= base_i;
      end else if (gnt_i) begin
        left_q <= left_q - count_t'(1);
        addr_o <= (addr_o == im_addr_t'(IM_DEPTH - 1)) ? '0 : addr_o + im_addr_t'(1);
      end
      if (gnt_i) begin
        pending_q <= 1'b1;
      end else if (rvalid_i) begin
        pending_q <= 1'b0;
      end
      // rvalid and pop never meet, a read is only issued when empty
      if (rvalid_i) begin
        full_o <= 1'b1;
      end else if (pop_i) begin
        full_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rvalid_i) begin
      hv_o <= rdata_i;
    end
  end

endmodule

`default_nettype wire

//--- hdl/im_shared_mem.sv
/*
 * Item memory shared by the host writer and the two fetchers.
 * One access per cycle: a host write always wins, the fetchers
 * share what is left round-robin. Read data and the rvalid of the
 * granted port come one cycle after the grant.
 */
`default_nettype none

module im_shared_mem import hdc_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     wr_en_i,
  input  im_addr_t wr_addr_i,
  input  hv_t      wr_data_i,
  input  logic     a_req_i,
  input  im_addr_t a_addr_i,
  input  logic     b_req_i,
  input  im_addr_t b_addr_i,
  output logic     a_gnt_o,
  output logic     a_rvalid_o,
  output logic     b_gnt_o,
  output logic     b_rvalid_o,
  output hv_t      rdata_o
);

  hv_t      mem_q [IM_DEPTH];
  logic     last_b_q;
  im_addr_t rd_addr;

  // --------------------------------------------------
  // Arbiter
  // --------------------------------------------------
  // On a tie the port that was not granted last goes first
  assign a_gnt_o = !wr_en_i && a_req_i && (!b_req_i || last_b_q);
  assign b_gnt_o = !wr_en_i && b_req_i && (!a_req_i || !last_b_q);

  assign rd_addr = a_gnt_o ? a_addr_i : b_addr_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      last_b_q   <= 1'b0;
      a_rvalid_o <= 1'b0;
      b_rvalid_o <= 1'b0;
    end else begin
      a_rvalid_o <= a_gnt_o;
      b_rvalid_o <= b_gnt_o;
      if (a_gnt_o) begin
        last_b_q <= 1'b0;
      end else if (b_gnt_o) begin
        last_b_q <= 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // Storage
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      mem_q[wr_addr_i] <= wr_data_i;
    end
  end

  // Single read port, shared by both fetchers
  always_ff @(posedge clk_i) begin
    if (a_gnt_o || b_gnt_o) begin
      rdata_o <= mem_q[rd_addr];
    end
  end

endmodule

`default_nettype wire

//--- hdl/hv_bundler.sv
/*
 * Run sequencer and bundler.
 * Accepts a start when idle with a non-zero item count, pops one A/B
 * pair whenever both fetchers are full, binds it by XOR and counts
 * ones per bit. After the last pair each bit is set by strict
 * majority and the query vector is strobed for one cycle.
 */
`default_nettype none

module hv_bundler import hdc_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_i,
  input  logic   start_req_i,
  input  count_t num_items_i,
  input  hv_t    a_hv_i,
  input  logic   a_full_i,
  input  hv_t    b_hv_i,
  input  logic   b_full_i,
  output logic   run_start_o,
  output logic   pop_o,
  output logic   busy_o,
  output logic   done_o,
  output hv_t    qhv_o,
  output logic   qhv_valid_o
);

  count_t cnt_q [HV_DIM];
  count_t cnt_d [HV_DIM];
  count_t items_q;
  count_t left_q;
  hv_t    bind_hv;
  hv_t    majority;
  logic   last_pop;

  assign run_start_o = start_req_i && !busy_o && (num_items_i != '0);
  assign pop_o       = busy_o && a_full_i && b_full_i;
  assign last_pop    = pop_o && (left_q == count_t'(1));
  assign bind_hv     = a_hv_i ^ b_hv_i;

  // --------------------------------------------------
  // Bundle counters and threshold
  // --------------------------------------------------
  // Threshold looks at the updated counts so the result is ready
  // at the edge that takes the last pair
  always_comb begin
    for (int i = 0; i < HV_DIM; i++) begin
      cnt_d[i]    = cnt_q[i] + count_t'(bind_hv[i]);
      majority[i] = ({cnt_d[i], 1'b0} > {1'b0, items_q});
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i || run_start_o) begin
      for (int i = 0; i < HV_DIM; i++) begin
        cnt_q[i] <= '0;
      end
    end else if (pop_o) begin
      for (int i = 0; i < HV_DIM; i++) begin
        cnt_q[i] <= cnt_d[i];
      end
    end
  end

  // --------------------------------------------------
  // Run control
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_o      <= 1'b0;
      done_o      <= 1'b0;
      qhv_valid_o <= 1'b0;
      items_q     <= '0;
      left_q      <= '0;
    end else begin
      qhv_valid_o <= last_pop;
      if (run_start_o) begin
        busy_o  <= 1'b1;
        done_o  <= 1'b0;
        items_q <= num_items_i;
        left_q  <= num_items_i;
      end else if (pop_o) begin
        left_q <= left_q - count_t'(1);
        if (last_pop) begin
          busy_o <= 1'b0;
          done_o <= 1'b1;
        end
      end
    end
  end

  // Result stays readable until the next run ends
  always_ff @(posedge clk_i) begin
    if (last_pop) begin
      qhv_o <= majority;
    end
  end

endmodule

`default_nettype wire

//--- hdl/hdc_encoder_top.sv
/*
 * Top level of the HDC encoder.
 * Joins the register block, both fetchers, the shared item memory
 * and the bundler. Only wires live here.
 */
`default_nettype none

module hdc_encoder_top import hdc_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_i,
  input  logic      csr_we_i,
  input  logic      csr_re_i,
  input  csr_addr_t csr_addr_i,
  input  csr_data_t csr_wdata_i,
  output csr_data_t csr_rdata_o,
  output logic      csr_rvalid_o,
  output hv_t       qhv_o,
  output logic      qhv_valid_o
);

  // --------------------------------------------------
  // Internal wires
  // --------------------------------------------------
  logic     start_req, run_start, pop, busy, done;
  count_t   num_items;
  im_addr_t base_a, base_b;
  logic     im_wr_en;
  im_addr_t im_wr_addr;
  hv_t      im_wr_data, im_rdata;
  // Fetch ports
  logic     a_req, a_gnt, a_rvalid, a_full;
  logic     b_req, b_gnt, b_rvalid, b_full;
  im_addr_t a_addr, b_addr;
  hv_t      a_hv, b_hv;

  hdc_csr u_csr (
    .clk_i        ( clk_i        ), .rst_i        ( rst_i        ),
    .csr_we_i     ( csr_we_i     ), .csr_re_i     ( csr_re_i     ),
    .csr_addr_i   ( csr_addr_i   ), .csr_wdata_i  ( csr_wdata_i  ),
    .busy_i       ( busy         ), .done_i       ( done         ),
    .result_i     ( qhv_o        ), .csr_rdata_o  ( csr_rdata_o  ),
    .csr_rvalid_o ( csr_rvalid_o ), .start_req_o  ( start_req    ),
    .num_items_o  ( num_items    ), .base_a_o     ( base_a       ),
    .base_b_o     ( base_b       ), .im_wr_en_o   ( im_wr_en     ),
    .im_wr_addr_o ( im_wr_addr   ), .im_wr_data_o ( im_wr_data   )
  );

  im_fetcher u_fetch_a (
    .clk_i ( clk_i ), .rst_i ( rst_i ), .run_start_i ( run_start ),
    .base_i ( base_a ), .num_items_i ( num_items ), .gnt_i ( a_gnt ),
    .rvalid_i ( a_rvalid ), .rdata_i ( im_rdata ), .pop_i ( pop ),
    .req_o ( a_req ), .addr_o ( a_addr ), .hv_o ( a_hv ), .full_o ( a_full )
  );

  im_fetcher u_fetch_b (
    .clk_i ( clk_i ), .rst_i ( rst_i ), .run_start_i ( run_start ),
    .base_i ( base_b ), .num_items_i ( num_items ), .gnt_i ( b_gnt ),
    .rvalid_i ( b_rvalid ), .rdata_i ( im_rdata ), .pop_i ( pop ),
    .req_o ( b_req ), .addr_o ( b_addr ), .hv_o ( b_hv ), .full_o ( b_full )
  );

  im_shared_mem u_mem (
    .clk_i ( clk_i ), .rst_i ( rst_i ), .wr_en_i ( im_wr_en ),
    .wr_addr_i ( im_wr_addr ), .wr_data_i ( im_wr_data ),
    .a_req_i ( a_req ), .a_addr_i ( a_addr ), .b_req_i ( b_req ), .b_addr_i ( b_addr ),
    .a_gnt_o ( a_gnt ), .a_rvalid_o ( a_rvalid ), .b_gnt_o ( b_gnt ),
    .b_rvalid_o ( b_rvalid ), .rdata_o ( im_rdata )
  );

  hv_bundler u_bundler (
    .clk_i ( clk_i ), .rst_i ( rst_i ), .start_req_i ( start_req ),
    .num_items_i ( num_items ), .a_hv_i ( a_hv ), .a_full_i ( a_full ),
    .b_hv_i ( b_hv ), .b_full_i ( b_full ), .run_start_o ( run_start ),
    .pop_o ( pop ), .busy_o ( busy ), .done_o ( done ),
    .qhv_o ( qhv_o ), .qhv_valid_o ( qhv_valid_o )
  );

endmodule

`default_nettype wire

//--- test/hdc_encoder_assertions.sv
/*
 * Protocol checker for the fetch ports of the item memory and the
 * result strobe. Bound into im_shared_mem and hv_bundler; inputs a
 * target lacks are tied low in its bind.
 */
`default_nettype none

module hdc_encoder_assertions import hdc_pkg::*; (
  input logic     clk_i,
  input logic     rst_i,
  input logic     wr_en_i,
  input logic     a_req_i,
  input im_addr_t a_addr_i,
  input logic     a_gnt_i,
  input logic     b_req_i,
  input im_addr_t b_addr_i,
  input logic     b_gnt_i,
  input logic     qhv_valid_i
);

  timeunit 1ns;
  timeprecision 1ps;

  // --------------------------------------------------
  // Fetch ports
  // --------------------------------------------------
  // A waiting request keeps its address until granted
  a_req_held: assert property (@(posedge clk_i) disable iff (rst_i)
    (a_req_i && !a_gnt_i) |=> (a_req_i && $stable(a_addr_i)))
    else $error("port A request dropped or moved before its grant");

  b_req_held: assert property (@(posedge clk_i) disable iff (rst_i)
    (b_req_i && !b_gnt_i) |=> (b_req_i && $stable(b_addr_i)))
    else $error("port B request dropped or moved before its grant");

  // Round robin, the loser of a tie wins the next free cycle
  a_not_starved: assert property (@(posedge clk_i) disable iff (rst_i)
    (a_req_i && !a_gnt_i && !wr_en_i) |=> (a_gnt_i || wr_en_i))
    else $error("port A passed over twice in a row");

  b_not_starved: assert property (@(posedge clk_i) disable iff (rst_i)
    (b_req_i && !b_gnt_i && !wr_en_i) |=> (b_gnt_i || wr_en_i))
    else $error("port B passed over twice in a row");

  // Result strobe
  qhv_single: assert property (@(posedge clk_i) disable iff (rst_i)
    qhv_valid_i |=> !qhv_valid_i)
    else $error("query valid held for two cycles");

endmodule

bind im_shared_mem hdc_encoder_assertions u_mem_checks (
  .clk_i       ( clk_i    ),
  .rst_i       ( rst_i    ),
  .wr_en_i     ( wr_en_i  ),
  .a_req_i     ( a_req_i  ),
  .a_addr_i    ( a_addr_i ),
  .a_gnt_i     ( a_gnt_o  ),
  .b_req_i     ( b_req_i  ),
  .b_addr_i    ( b_addr_i ),
  .b_gnt_i     ( b_gnt_o  ),
  .qhv_valid_i ( 1'b0     )
);

bind hv_bundler hdc_encoder_assertions u_bundler_checks (
  .clk_i       ( clk_i       ),
  .rst_i       ( rst_i       ),
  .wr_en_i     ( 1'b0        ),
  .a_req_i     ( 1'b0        ),
  .a_addr_i    ( '0          ),
  .a_gnt_i     ( 1'b0        ),
  .b_req_i     ( 1'b0        ),
  .b_addr_i    ( '0          ),
  .b_gnt_i     ( 1'b0        ),
  .qhv_valid_i ( qhv_valid_o )
);

`default_nettype wire

//--- test/tb_hdc_encoder.sv
/*
 * Directed testbench for the HDC encoder top level.
 * Loads the item memory with LFSR vectors, runs bundling jobs through
 * the host registers and checks each result against a reference model
 * kept here. Stops at the first error.
 */
`default_nettype none

module tb_hdc_encoder import hdc_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int          READ_TIMEOUT = 8;
  localparam int          RUN_TIMEOUT  = 300;
  localparam logic [15:0] LFSR_SEED    = 16'd16242;

  logic      clk;
  logic      rst;
  logic      csr_we;
  logic      csr_re;
  csr_addr_t csr_addr;
  csr_data_t csr_wdata;
  csr_data_t csr_rdata;
  logic      csr_rvalid;
  hv_t       qhv;
  logic      qhv_valid;

  logic [15:0] lfsr_state;
  // Copy of what the host wrote into the item memory
  hv_t         items_ref [IM_DEPTH];

  hdc_encoder_top u_dut (
    .clk_i        ( clk        ),
    .rst_i        ( rst        ),
    .csr_we_i     ( csr_we     ),
    .csr_re_i     ( csr_re     ),
    .csr_addr_i   ( csr_addr   ),
    .csr_wdata_i  ( csr_wdata  ),
    .csr_rdata_o  ( csr_rdata  ),
    .csr_rvalid_o ( csr_rvalid ),
    .qhv_o        ( qhv        ),
    .qhv_valid_o  ( qhv_valid  )
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // --------------------------------------------------
  // Error reporting and compare tasks
  // --------------------------------------------------
  task automatic report_abort(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic check_hv(input string what, input hv_t got, input hv_t exp);
    if (got !== exp) begin
      report_abort($sformatf("Fail at %0t ns: %s, got %h expected %h",
                             $time, what, got, exp));
    end
  endtask

  task automatic check_word(input string what, input csr_data_t got, input csr_data_t exp);
    if (got !== exp) begin
      report_abort($sformatf("Fail at %0t ns: %s, got %h expected %h",
                             $time, what, got, exp));
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      report_abort($sformatf("Fail at %0t ns: %s, got %b expected %b",
                             $time, what, got, exp));
    end
  endtask

  // --------------------------------------------------
  // Stimulus source and reference model
  // --------------------------------------------------
  // Fibonacci form, taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  task automatic draw_hv(output hv_t v);
    for (int i = 0; i < HV_DIM; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v[i] = lfsr_state[0];
    end
  endtask

  // Bind pairs by XOR, count ones per bit, strict majority
  task automatic model_query(input int base_a, input int base_b, input int n,
                             output hv_t q, output hv_t ties);
    int       ones [HV_DIM];
    hv_t      bound;
    im_addr_t ia;
    im_addr_t ib;
    for (int i = 0; i < HV_DIM; i++) begin
      ones[i] = 0;
    end
    for (int k = 0; k < n; k++) begin
      ia = im_addr_t'((base_a + k) % IM_DEPTH);
      ib = im_addr_t'((base_b + k) % IM_DEPTH);
      bound = items_ref[ia] ^ items_ref[ib];
      for (int i = 0; i < HV_DIM; i++) begin
        if (bound[i]) begin
          ones[i]++;
        end
      end
    end
    for (int i = 0; i < HV_DIM; i++) begin
      q[i]    = (2 * ones[i] > n);
      ties[i] = (2 * ones[i] == n);
    end
  endtask

  // --------------------------------------------------
  // Host bus and wait tasks
  // --------------------------------------------------
  task automatic apply_reset();
    rst <= 1'b1;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
  endtask

  task automatic csr_write(input csr_addr_t addr, input csr_data_t data);
    @(posedge clk);
    csr_we    <= 1'b1;
    csr_addr  <= addr;
    csr_wdata <= data;
    @(posedge clk);
    csr_we    <= 1'b0;
  endtask

  task automatic csr_read(input csr_addr_t addr, output csr_data_t data);
    int waited;
    @(posedge clk);
    csr_re   <= 1'b1;
    csr_addr <= addr;
    @(posedge clk);
    csr_re   <= 1'b0;
    waited = 0;
    @(negedge clk);
    while (!csr_rvalid) begin
      if (waited >= READ_TIMEOUT) begin
        report_abort("Timed out waiting for a register read response");
      end
      waited++;
      @(negedge clk);
    end
    data = csr_rdata;
    check_bit("read response one cycle after strobe", waited == 0, 1'b1);
    @(negedge clk);
    check_bit("read valid lasts one cycle", csr_rvalid, 1'b0);
  endtask

  task automatic wait_query(output hv_t q);
    int waited;
    waited = 0;
    @(negedge clk);
    while (!qhv_valid) begin
      if (waited >= RUN_TIMEOUT) begin
        report_abort("Timed out waiting for the query result strobe");
      end
      waited++;
      @(negedge clk);
    end
    q = qhv;
  endtask

  task automatic count_strobes(input int cycles, output int seen);
    seen = 0;
    repeat (cycles) begin
      @(negedge clk);
      if (qhv_valid) begin
        seen++;
      end
    end
  endtask

  task automatic start_run(input int base_a, input int base_b, input int n);
    csr_write(REG_NUM_ITEMS, csr_data_t'(n));
    csr_write(REG_BASE_A, csr_data_t'(base_a));
    csr_write(REG_BASE_B, csr_data_t'(base_b));
    csr_write(REG_CTRL, 32'h0000_0001);
  endtask

  task automatic load_items();
    hv_t v;
    for (int k = 0; k < IM_DEPTH; k++) begin
      draw_hv(v);
      items_ref[k] = v;
      csr_write(IM_WIN_BASE + csr_addr_t'(k), v);
    end
  endtask

  // --------------------------------------------------
  // Tests
  // --------------------------------------------------
  task automatic test_register_access();
    csr_data_t rd;
    csr_write(REG_NUM_ITEMS, 32'h0000_005A);
    csr_write(REG_BASE_A, 32'h0000_0007);
    csr_write(REG_BASE_B, 32'h0000_000C);
    csr_read(REG_NUM_ITEMS, rd);
    check_word("NUM_ITEMS readback", rd, 32'h0000_005A);
    csr_read(REG_BASE_A, rd);
    check_word("BASE_A readback", rd, 32'h0000_0007);
    csr_read(REG_BASE_B, rd);
    check_word("BASE_B readback", rd, 32'h0000_000C);
    csr_read(8'h06, rd);
    check_word("unmapped 0x06", rd, '0);
    csr_read(8'hFF, rd);
    check_word("unmapped 0xFF", rd, '0);
    csr_read(REG_STATUS, rd);
    check_bit("busy after reset", rd[STATUS_BUSY_BIT], 1'b0);
    check_bit("done after reset", rd[STATUS_DONE_BIT], 1'b0);
  endtask

  task automatic test_single_item();
    hv_t q;
    load_items();
    start_run(2, 9, 1);
    wait_query(q);
    check_hv("single item bind", q, items_ref[2] ^ items_ref[9]);
  endtask

  task automatic test_majority_five();
    hv_t       q;
    hv_t       exp;
    hv_t       ties;
    csr_data_t rd;
    start_run(0, 5, 5);
    wait_query(q);
    model_query(0, 5, 5, exp, ties);
    check_hv("five item majority", q, exp);
    csr_read(REG_RESULT, rd);
    check_word("RESULT register", rd, csr_data_t'(exp));
    csr_read(REG_STATUS, rd);
    check_bit("busy after run", rd[STATUS_BUSY_BIT], 1'b0);
    check_bit("done after run", rd[STATUS_DONE_BIT], 1'b1);
  endtask

  // A walks 14, 15, 0, 1 and an even count allows ties
  task automatic test_wrap_and_tie();
    hv_t q;
    hv_t exp;
    hv_t ties;
    start_run(14, 3, 4);
    wait_query(q);
    model_query(14, 3, 4, exp, ties);
    // Without a tied bit the zero rule would go unexercised
    check_bit("tied bits in stimulus", |ties, 1'b1);
    check_hv("wrapped four item result", q, exp);
  endtask

  task automatic test_start_while_busy();
    hv_t       q;
    hv_t       exp;
    hv_t       ties;
    csr_data_t rd;
    int        seen;
    start_run(1, 8, 6);
    csr_read(REG_STATUS, rd);
    check_bit("busy during run", rd[STATUS_BUSY_BIT], 1'b1);
    // New count would show in the result if the restart were taken
    csr_write(REG_NUM_ITEMS, 32'h0000_0002);
    csr_write(REG_CTRL, 32'h0000_0001);
    wait_query(q);
    model_query(1, 8, 6, exp, ties);
    check_hv("result with ignored restart", q, exp);
    count_strobes(RUN_TIMEOUT, seen);
    check_word("extra result strobes", csr_data_t'(seen), '0);
  endtask

  task automatic test_zero_items();
    csr_data_t rd;
    int        seen;
    csr_write(REG_NUM_ITEMS, '0);
    csr_write(REG_CTRL, 32'h0000_0001);
    count_strobes(RUN_TIMEOUT, seen);
    check_word("strobes for an empty run", csr_data_t'(seen), '0);
    csr_read(REG_STATUS, rd);
    check_bit("busy after empty start", rd[STATUS_BUSY_BIT], 1'b0);
    // Done survives because the start was never accepted
    check_bit("done after empty start", rd[STATUS_DONE_BIT], 1'b1);
  endtask

  initial begin
    rst        = 1'b1;
    csr_we     = 1'b0;
    csr_re     = 1'b0;
    csr_addr   = '0;
    csr_wdata  = '0;
    lfsr_state = LFSR_SEED;
    apply_reset();
    @(negedge clk);
    check_bit("read valid after reset", csr_rvalid, 1'b0);
    check_bit("result strobe after reset", qhv_valid, 1'b0);
    test_register_access();
    test_single_item();
    test_majority_five();
    test_wrap_and_tie();
    test_start_while_busy();
    test_zero_items();
    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
hdl/hdc_pkg.sv
hdl/hdc_csr.sv
hdl/im_fetcher.sv
hdl/im_shared_mem.sv
hdl/hv_bundler.sv
hdl/hdc_encoder_top.sv
test/hdc_encoder_assertions.sv
test/tb_hdc_encoder.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_hdc_encoder
FILELIST   := filelist.f
BUILD_DIR  := obj_dir
VFLAGS     := --binary --timing --assert -j 0 --Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
